/* all.f */
+incdir+tests
rtl/lsq_pkg.sv
rtl/sq_ring_ctrl.sv
rtl/sq_entry_array.sv
rtl/sq_forward.sv
rtl/store_queue.sv
tests/store_queue_tb.sv

/* tests/sq_vectors.svh */
// One row per cycle with its inputs followed by the outputs expected in that cycle
// en dsp rb rb_idx | ex ex_idx ex_addr ex_dsel | ld_addr ld_idx | ret
//   | rdy alloc rok hit fwd_dsel | wen wr_addr wr_dsel
// A *_dsel column indexes data_pool whose entry 0 is all zero

localparam lsq_pkg::sq_addr_t A_0 = '0;
localparam lsq_pkg::sq_addr_t A_X = 61'h1000;
localparam lsq_pkg::sq_addr_t A_Y = 61'h2000;
localparam lsq_pkg::sq_addr_t A_Z = 61'h3000;

localparam int N_ROWS = 25;

typedef struct packed {
  int                en;
  int                dispatch;
  int                rollback;
  int                rollback_idx;
  int                exec;
  int                exec_idx;
  lsq_pkg::sq_addr_t exec_addr;
  int                exec_dsel;
  lsq_pkg::sq_addr_t load_addr;
  int                load_idx;
  int                retire;
  int                exp_ready;
  int                exp_alloc;
  int                exp_retire_ok;
  int                exp_hit;
  int                exp_fwd_dsel;
  int                exp_wr_en;
  lsq_pkg::sq_addr_t exp_wr_addr;
  int                exp_wr_dsel;
} vec_row_t;

vec_row_t vectors [0:N_ROWS-1] = '{
  '{1, 0, 0, 0, 0, 0, A_0, 0, A_0, 0, 0, 1, 0, 0, 0, 0, 0, A_0, 0},
  // Seven allocations fill the ring
  '{1, 1, 0, 0, 0, 0, A_0, 0, A_0, 0, 0, 1, 0, 0, 0, 0, 0, A_0, 0},
  '{1, 1, 0, 0, 0, 0, A_0, 0, A_0, 0, 0, 1, 1, 0, 0, 0, 0, A_0, 0},
  '{1, 1, 0, 0, 0, 0, A_0, 0, A_0, 0, 0, 1, 2, 0, 0, 0, 0, A_0, 0},
  '{1, 1, 0, 0, 0, 0, A_0, 0, A_0, 0, 0, 1, 3, 0, 0, 0, 0, A_0, 0},
  '{1, 1, 0, 0, 0, 0, A_0, 0, A_0, 0, 0, 1, 4, 0, 0, 0, 0, A_0, 0},
  '{1, 1, 0, 0, 0, 0, A_0, 0, A_0, 0, 0, 1, 5, 0, 0, 0, 0, A_0, 0},
  '{1, 1, 0, 0, 0, 0, A_0, 0, A_0, 0, 0, 1, 6, 0, 0, 0, 0, A_0, 0},
  // Full ring whose unexecuted slots all hold the load's address
  '{1, 0, 0, 0, 0, 0, A_0, 0, A_0, 4, 0, 0, 7, 0, 0, 0, 0, A_0, 0},
  '{1, 0, 0, 0, 1, 1, A_X, 1, A_0, 0, 0, 0, 7, 0, 0, 0, 0, A_0, 0},
  '{1, 0, 0, 0, 1, 3, A_X, 2, A_X, 4, 0, 0, 7, 0, 1, 1, 0, A_0, 0},
  '{1, 0, 0, 0, 1, 0, A_Y, 3, A_X, 4, 0, 0, 7, 0, 1, 2, 0, A_0, 0},
  '{1, 0, 0, 0, 1, 2, A_Z, 4, A_X, 2, 0, 0, 7, 1, 1, 1, 0, A_0, 0},
  '{1, 0, 0, 0, 0, 0, A_0, 0, A_X, 1, 0, 0, 7, 1, 0, 0, 0, A_0, 0},
  '{1, 0, 0, 0, 0, 0, A_0, 0, A_Y, 1, 0, 0, 7, 1, 1, 3, 0, A_0, 0},
  // Rollback squashes slots two and up
  '{1, 0, 1, 2, 0, 0, A_0, 0, A_Z, 2, 0, 0, 7, 1, 0, 0, 0, A_0, 0},
  '{1, 0, 0, 0, 0, 0, A_0, 0, A_X, 2, 1, 1, 2, 1, 1, 1, 1, A_Y, 3},
  '{1, 0, 0, 0, 0, 0, A_0, 0, A_0, 0, 1, 1, 2, 1, 0, 0, 1, A_X, 1},
  '{1, 0, 0, 0, 0, 0, A_0, 0, A_0, 0, 1, 1, 2, 0, 0, 0, 0, A_0, 0},
  // Slot two reused
  '{1, 1, 0, 0, 0, 0, A_0, 0, A_0, 0, 0, 1, 2, 0, 0, 0, 0, A_0, 0},
  '{1, 0, 0, 0, 1, 2, A_Y, 5, A_0, 0, 1, 1, 3, 0, 0, 0, 0, A_0, 0},
  '{1, 0, 0, 0, 0, 0, A_0, 0, A_Y, 3, 0, 1, 3, 1, 1, 5, 0, A_0, 0},
  // Frozen cycle
  '{0, 1, 0, 0, 1, 2, A_Z, 6, A_0, 0, 1, 1, 3, 1, 0, 0, 0, A_0, 0},
  '{1, 0, 0, 0, 0, 0, A_0, 0, A_Y, 3, 1, 1, 3, 1, 1, 5, 1, A_Y, 5},
  '{1, 0, 0, 0, 0, 0, A_0, 0, A_0, 0, 0, 1, 3, 0, 0, 0, 0, A_0, 0}
};

/* tests/store_queue_tb.sv */
`timescale 1ns/10ps

module store_queue_tb;

  localparam int DEPTH = 8;
  localparam int IDX_W = $clog2(DEPTH);
  localparam int N_DATA = 7;

  logic                    clock;
  logic                    reset;
  logic                    en;
  logic                    dispatch_en;
  logic                    rollback_en;
  logic [IDX_W-1:0]        rollback_idx;
  logic                    exec_en;
  logic [IDX_W-1:0]        exec_idx;
  lsq_pkg::sq_addr_t       exec_addr;
  lsq_pkg::sq_data_t       exec_data;
  lsq_pkg::sq_addr_t       load_addr;
  logic [IDX_W-1:0]        load_sq_idx;
  logic                    retire_en;
  logic                    dispatch_ready;
  logic [IDX_W-1:0]        alloc_idx;
  logic                    retire_ok;
  logic                    fwd_hit;
  lsq_pkg::sq_data_t       fwd_data;
  logic                    mem_wr_en;
  lsq_pkg::sq_addr_t       mem_wr_addr;
  lsq_pkg::sq_data_t       mem_wr_data;

  lsq_pkg::sq_data_t data_pool [0:N_DATA-1];
  int                error_count;
  int                cycle_count;
  int                row_num;

  `include "sq_vectors.svh"

  localparam int TIMEOUT_CYCLES = N_ROWS + 4 + 20;

  store_queue #(
    .DEPTH (DEPTH)
  ) i_dut (
    .clock          (clock),
    .reset          (reset),
    .en             (en),
    .dispatch_en    (dispatch_en),
    .rollback_en    (rollback_en),
    .rollback_idx   (rollback_idx),
    .exec_en        (exec_en),
    .exec_idx       (exec_idx),
    .exec_addr      (exec_addr),
    .exec_data      (exec_data),
    .load_addr      (load_addr),
    .load_sq_idx    (load_sq_idx),
    .retire_en      (retire_en),
    .dispatch_ready (dispatch_ready),
    .alloc_idx      (alloc_idx),
    .retire_ok      (retire_ok),
    .fwd_hit        (fwd_hit),
    .fwd_data       (fwd_data),
    .mem_wr_en      (mem_wr_en),
    .mem_wr_addr    (mem_wr_addr),
    .mem_wr_data    (mem_wr_data)
  );

  initial clock = 1'b0;
  always #20 clock = ~clock;

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  task automatic fill_data_pool();
    logic [15:0]       state;
    lsq_pkg::sq_data_t word;
    state = 16'd88;
    data_pool[0] = '0;
    for (int n = 1; n < N_DATA; n++) begin
      word = '0;
      for (int b = 0; b < lsq_pkg::DATA_W; b++) begin
        word = {word[lsq_pkg::DATA_W-2:0], state[15]};
        state = lfsr_next(state);
      end
      data_pool[n] = word;
    end
  endtask

  task automatic check_data(input string name, input lsq_pkg::sq_data_t expected,
                            input lsq_pkg::sq_data_t actual);
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t ns row %0d: %s expected %h, got %h",
               $time, row_num, name, expected, actual);
    end
  endtask

  task automatic check_addr(input string name, input lsq_pkg::sq_addr_t expected,
                            input lsq_pkg::sq_addr_t actual);
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t ns row %0d: %s expected %h, got %h",
               $time, row_num, name, expected, actual);
    end
  endtask

  task automatic check_bits(input string name, input logic [IDX_W-1:0] expected,
                            input logic [IDX_W-1:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t ns row %0d: %s expected %0h, got %0h",
               $time, row_num, name, expected, actual);
    end
  endtask

  task automatic apply_row(input vec_row_t row);
    en           <= (row.en != 0);
    dispatch_en  <= (row.dispatch != 0);
    rollback_en  <= (row.rollback != 0);
    rollback_idx <= IDX_W'(row.rollback_idx);
    exec_en      <= (row.exec != 0);
    exec_idx     <= IDX_W'(row.exec_idx);
    exec_addr    <= row.exec_addr;
    exec_data    <= data_pool[row.exec_dsel];
    load_addr    <= row.load_addr;
    load_sq_idx  <= IDX_W'(row.load_idx);
    retire_en    <= (row.retire != 0);
  endtask

  task automatic check_row(input vec_row_t row);
    check_bits("dispatch_ready", IDX_W'(row.exp_ready), IDX_W'(dispatch_ready));
    check_bits("alloc_idx", IDX_W'(row.exp_alloc), alloc_idx);
    check_bits("retire_ok", IDX_W'(row.exp_retire_ok), IDX_W'(retire_ok));
    check_bits("fwd_hit", IDX_W'(row.exp_hit), IDX_W'(fwd_hit));
    check_data("fwd_data", data_pool[row.exp_fwd_dsel], fwd_data);
    check_bits("mem_wr_en", IDX_W'(row.exp_wr_en), IDX_W'(mem_wr_en));
    // Cache port contents only matter while a write is offered
    if (row.exp_wr_en != 0) begin
      check_addr("mem_wr_addr", row.exp_wr_addr, mem_wr_addr);
      check_data("mem_wr_data", data_pool[row.exp_wr_dsel], mem_wr_data);
    end
  endtask

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles without reaching the end of the table",
               cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    reset        = 1'b1;
    en           = 1'b0;
    dispatch_en  = 1'b0;
    rollback_en  = 1'b0;
    rollback_idx = '0;
    exec_en      = 1'b0;
    exec_idx     = '0;
    exec_addr    = '0;
    exec_data    = '0;
    load_addr    = '0;
    load_sq_idx  = '0;
    retire_en    = 1'b0;
    error_count  = 0;
    cycle_count  = 0;
    row_num      = 0;
    fill_data_pool();

    repeat (4) @(posedge clock);
    reset <= 1'b0;

    for (int r = 0; r < N_ROWS; r++) begin
      @(posedge clock);
      row_num = r;
      apply_row(vectors[r]);
      @(negedge clock);
      check_row(vectors[r]);
    end

    $display("Store queue table done: %0d rows, %0d errors", N_ROWS, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* rtl/store_queue.sv */
`timescale 1ns/10ps

module store_queue #(
  parameter int DEPTH = lsq_pkg::SQ_DEPTH
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     en,
  input  logic                     dispatch_en,
  input  logic                     rollback_en,
  input  logic [$clog2(DEPTH)-1:0] rollback_idx,
  input  logic                     exec_en,
  input  logic [$clog2(DEPTH)-1:0] exec_idx,
  input  lsq_pkg::sq_addr_t        exec_addr,
  input  lsq_pkg::sq_data_t        exec_data,
  input  lsq_pkg::sq_addr_t        load_addr,
  input  logic [$clog2(DEPTH)-1:0] load_sq_idx,
  input  logic                     retire_en,
  output logic                     dispatch_ready,
  output logic [$clog2(DEPTH)-1:0] alloc_idx,
  output logic                     retire_ok,
  output logic                     fwd_hit,
  output lsq_pkg::sq_data_t        fwd_data,
  output logic                     mem_wr_en,
  output lsq_pkg::sq_addr_t        mem_wr_addr,
  output lsq_pkg::sq_data_t        mem_wr_data
);

  localparam int IDX_W = $clog2(DEPTH);

  logic [IDX_W-1:0]               head;
  logic [IDX_W-1:0]               tail;
  lsq_pkg::sq_entry_t [DEPTH-1:0] entries;
  lsq_pkg::sq_entry_t             head_entry;

  // New store goes to the current tail
  assign alloc_idx = tail;

  // Data cache write port reads straight from the head slot
  assign mem_wr_addr = head_entry.addr;
  assign mem_wr_data = head_entry.data;

  sq_ring_ctrl #(
    .DEPTH (DEPTH)
  ) i_ring_ctrl (
    .clock          (clock),
    .reset          (reset),
    .en             (en),
    .dispatch_en    (dispatch_en),
    .rollback_en    (rollback_en),
    .rollback_idx   (rollback_idx),
    .retire_en      (retire_en),
    .head_executed  (head_entry.executed),
    .head           (head),
    .tail           (tail),
    .dispatch_ready (dispatch_ready),
    .retire_ok      (retire_ok),
    .retire_fire    (mem_wr_en)
  );

  sq_entry_array #(
    .DEPTH (DEPTH)
  ) i_entry_array (
    .clock      (clock),
    .reset      (reset),
    .en         (en),
    .alloc      (dispatch_en),
    .tail       (tail),
    .exec_en    (exec_en),
    .exec_idx   (exec_idx),
    .exec_addr  (exec_addr),
    .exec_data  (exec_data),
    .head       (head),
    .entries    (entries),
    .head_entry (head_entry)
  );

  sq_forward #(
    .DEPTH (DEPTH)
  ) i_forward (
    .entries     (entries),
    .head        (head),
    .load_sq_idx (load_sq_idx),
    .load_addr   (load_addr),
    .fwd_hit     (fwd_hit),
    .fwd_data    (fwd_data)
  );

endmodule

/* rtl/sq_forward.sv */
`timescale 1ns/10ps

module sq_forward #(
  parameter int DEPTH = lsq_pkg::SQ_DEPTH
) (
  input  lsq_pkg::sq_entry_t [DEPTH-1:0] entries,
  input  logic [$clog2(DEPTH)-1:0]       head,
  input  logic [$clog2(DEPTH)-1:0]       load_sq_idx,
  input  lsq_pkg::sq_addr_t              load_addr,
  output logic                           fwd_hit,
  output lsq_pkg::sq_data_t              fwd_data
);

  localparam int IDX_W = $clog2(DEPTH);

  logic [IDX_W-1:0]            older_cnt;
  logic [DEPTH-1:0][IDX_W-1:0] age_slot;
  logic [DEPTH-1:0]            match;

  // Number of stores ahead of the load
  assign older_cnt = load_sq_idx - head;

  // Age rank k sits in physical slot head + k
  always_comb begin
    for (int k = 0; k < DEPTH; k++) begin
      age_slot[k] = head + IDX_W'(k);
    end
  end

  always_comb begin
    for (int k = 0; k < DEPTH; k++) begin
      match[k] = (IDX_W'(k) < older_cnt) &&
                 entries[age_slot[k]].executed &&
                 (entries[age_slot[k]].addr == load_addr);
    end
  end

  // Youngest older store wins
  always_comb begin
    fwd_hit  = 1'b0;
    fwd_data = '0;
    for (int k = DEPTH - 1; k >= 0; k--) begin
      if (match[k] && !fwd_hit) begin
        fwd_hit  = 1'b1;
        fwd_data = entries[age_slot[k]].data;
      end
    end
  end

endmodule

/* rtl/sq_entry_array.sv */
`timescale 1ns/10ps

module sq_entry_array #(
  parameter int DEPTH = lsq_pkg::SQ_DEPTH
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           en,
  input  logic                           alloc,
  input  logic [$clog2(DEPTH)-1:0]       tail,
  input  logic                           exec_en,
  input  logic [$clog2(DEPTH)-1:0]       exec_idx,
  input  lsq_pkg::sq_addr_t              exec_addr,
  input  lsq_pkg::sq_data_t              exec_data,
  input  logic [$clog2(DEPTH)-1:0]       head,
  output lsq_pkg::sq_entry_t [DEPTH-1:0] entries,
  output lsq_pkg::sq_entry_t             head_entry
);

  always_ff @(posedge clock) begin
    if (reset) begin
      entries <= '0;
    end else if (en) begin
      // Fresh slot starts unexecuted
      if (alloc) begin
        entries[tail] <= '0;
      end
      if (exec_en) begin
        entries[exec_idx].addr     <= exec_addr;
        entries[exec_idx].data     <= exec_data;
        entries[exec_idx].executed <= 1'b1;
      end
    end
  end

  assign head_entry = entries[head];

  // A store executes once per allocation
  assert property (@(posedge clock) disable iff (reset)
    en && exec_en |-> !entries[exec_idx].executed)
    else $error("store queue execute into already executed slot %0d", exec_idx);

endmodule

/* rtl/sq_ring_ctrl.sv */
`timescale 1ns/10ps

module sq_ring_ctrl #(
  parameter int DEPTH = lsq_pkg::SQ_DEPTH
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     en,
  input  logic                     dispatch_en,
  input  logic                     rollback_en,
  input  logic [$clog2(DEPTH)-1:0] rollback_idx,
  input  logic                     retire_en,
  input  logic                     head_executed,
  output logic [$clog2(DEPTH)-1:0] head,
  output logic [$clog2(DEPTH)-1:0] tail,
  output logic                     dispatch_ready,
  output logic                     retire_ok,
  output logic                     retire_fire
);

  localparam int IDX_W = $clog2(DEPTH);

  logic [IDX_W-1:0] next_head;
  logic [IDX_W-1:0] next_tail;
  logic [IDX_W-1:0] occupancy;
  logic [IDX_W-1:0] rollback_dist;
  logic             empty;
  logic             full;

  // Distances from head wrap modulo DEPTH
  assign occupancy     = tail - head;
  assign rollback_dist = rollback_idx - head;

  // One slot stays free so head == tail only means empty
  assign empty = (occupancy == '0);
  assign full  = (occupancy == IDX_W'(DEPTH - 1));

  assign dispatch_ready = !full;
  assign retire_ok      = !empty && head_executed;
  assign retire_fire    = en && retire_en && retire_ok;

  assign next_head = retire_fire ? head + IDX_W'(1) : head;

  // Rollback wins over a same-cycle dispatch
  always_comb begin
    if (rollback_en) begin
      next_tail = rollback_idx;
    end else if (dispatch_en) begin
      next_tail = tail + IDX_W'(1);
    end else begin
      next_tail = tail;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
    end else if (en) begin
      head <= next_head;
      tail <= next_tail;
    end
  end

  // Allocation into a full ring would land on the head store
  assert property (@(posedge clock) disable iff (reset)
    en && dispatch_en && !rollback_en |-> dispatch_ready)
    else $error("store queue dispatch while full");

  // Rollback target inside head..tail, and never the head that retires this cycle
  assert property (@(posedge clock) disable iff (reset)
    en && rollback_en |-> (rollback_dist <= occupancy) &&
                          !(retire_fire && rollback_dist == '0))
    else $error("store queue rollback outside occupied range");

endmodule

/* rtl/lsq_pkg.sv */
package lsq_pkg;

  // Queue slots as a power of two so pointers wrap for free
  localparam int SQ_DEPTH = 8;

  // Doubleword address is the byte address without its low three bits
  localparam int ADDR_W = 61;

  localparam int DATA_W = 64;

  typedef logic [ADDR_W-1:0] sq_addr_t;

  typedef logic [DATA_W-1:0] sq_data_t;

  // One store slot of 126 bits
  typedef struct packed {
    sq_addr_t addr;
    sq_data_t data;
    logic     executed;
  } sq_entry_t;

endpackage
